/* src/mips_pkg.sv */
/*
  Shared widths, opcode and funct encodings, instruction formats and control types
  for the five-stage pipeline. Every core module imports this package.
*/
package mips_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int dmem_words = 64;    // indexed by alu result bits 7:2

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0]           imm;
    } i_fmt_t;

    // one fetched word, read as R-format or I-format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_op_t;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic alu_src_imm;     // b operand is the immediate
        logic reg_dst_rd;      // dest is rd, else rt
        logic alu_from_funct;  // alu op taken from funct
    } ctrl_t;

    typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_t;

endpackage

/* src/hazard_unit.sv */
/*
  Load-use and RAW hazard logic for the decode stage. Raises a one-cycle stall on
  a match with execute, otherwise selects forwarding from memory or writeback.
*/
`timescale 1ns/100ps

module hazard_unit (
    input  mips_pkg::instr_t               d_instr,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_dest,
    input  logic                           ex_reg_write,
    input  logic [mips_pkg::reg_addr_w-1:0] mem_dest,
    input  logic                           mem_reg_write,
    input  logic [mips_pkg::reg_addr_w-1:0] wb_dest,
    input  logic                           wb_reg_write,
    output logic                           stall,
    output mips_pkg::fwd_sel_t             fwd_a,
    output mips_pkg::fwd_sel_t             fwd_b
);
    import mips_pkg::*;

    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic                  rt_read;
    logic                  ex_hit_a;
    logic                  ex_hit_b;

    // memory stage wins as it holds the younger value
    function automatic fwd_sel_t fwd_pick(input logic [reg_addr_w-1:0] src);
        fwd_sel_t sel;
        sel = fwd_none;
        if (src != '0)
        begin
            if (mem_reg_write && mem_dest == src)
                sel = fwd_mem;
            else if (wb_reg_write && wb_dest == src)
                sel = fwd_wb;
        end
        return sel;
    endfunction

    assign rs      = d_instr.r.rs;
    assign rt      = d_instr.r.rt;
    assign rt_read = (d_instr.r.opcode == op_rtype) || (d_instr.r.opcode == op_sw);

    assign ex_hit_a = ex_reg_write && (ex_dest != '0) && (ex_dest == rs);
    assign ex_hit_b = ex_reg_write && (ex_dest != '0) && (ex_dest == rt) && rt_read;

    assign stall = ex_hit_a || ex_hit_b;

    always_comb
    begin
        fwd_a = fwd_pick(rs);
        fwd_b = fwd_pick(rt);
    end

endmodule

/* src/reg_file.sv */
/*
  32 x 32 register file, register 0 fixed at zero. Two operand read ports and a
  debug read port, all combinational, plus one write port clocked on SYS_clk.
*/
`timescale 1ns/100ps

module reg_file (
    input  logic                            SYS_clk,
    input  logic                            SYS_reset,
    input  logic [mips_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_pkg::reg_addr_w-1:0] rt_addr,
    input  logic [mips_pkg::reg_addr_w-1:0] dbg_addr,
    input  logic                            write,
    input  logic [mips_pkg::reg_addr_w-1:0] write_addr,
    input  logic [mips_pkg::xlen-1:0]       write_data,
    output logic [mips_pkg::xlen-1:0]       rs_data,
    output logic [mips_pkg::xlen-1:0]       rt_data,
    output logic [mips_pkg::xlen-1:0]       dbg_data
);
    import mips_pkg::*;

    logic [xlen-1:0] regs [1:31];    // r0 is not stored

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int k = 1; k < 32; k++)
                regs[k] <= '0;
        end
        else if (write && write_addr != '0)
        begin
            regs[write_addr] <= write_data;
        end
    end

    assign rs_data  = (rs_addr == '0)  ? '0 : regs[rs_addr];
    assign rt_data  = (rt_addr == '0)  ? '0 : regs[rt_addr];
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

    a_write_addr_known: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        write |-> !$isunknown(write_addr))
        else $error("register write with unknown address");

endmodule

/* src/decode_stage.sv */
/*
  Decode stage: holds the fetched word, decodes control, reads the register file
  and resolves forwarding. Outputs feed the execute register combinationally.
*/
`timescale 1ns/100ps

module decode_stage (
    input  logic                            SYS_clk,
    input  logic                            SYS_reset,
    input  mips_pkg::instr_t                fetch_instr,
    input  logic                            stall,
    input  mips_pkg::fwd_sel_t              fwd_a,
    input  mips_pkg::fwd_sel_t              fwd_b,
    input  logic [mips_pkg::xlen-1:0]       mem_result,
    input  logic                            wb_write,
    input  logic [mips_pkg::reg_addr_w-1:0] wb_dest,
    input  logic [mips_pkg::xlen-1:0]       wb_data,
    input  logic [mips_pkg::reg_addr_w-1:0] dbg_addr,
    output mips_pkg::instr_t                d_instr,
    output mips_pkg::ctrl_t                 d_ctrl,
    output logic [mips_pkg::xlen-1:0]       d_op_a,
    output logic [mips_pkg::xlen-1:0]       d_op_b,
    output logic [mips_pkg::xlen-1:0]       d_imm,
    output logic [mips_pkg::reg_addr_w-1:0] d_dest,
    output logic [mips_pkg::xlen-1:0]       dbg_data
);
    import mips_pkg::*;

    logic [xlen-1:0] rf_rs;
    logic [xlen-1:0] rf_rt;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            d_instr <= '0;           // all zero word is a nop
        else if (!stall)
            d_instr <= fetch_instr;
    end

    always_comb
    begin
        d_ctrl = '0;
        case (d_instr.r.opcode)
            op_rtype:
            begin
                d_ctrl.reg_write      = 1'b1;
                d_ctrl.reg_dst_rd     = 1'b1;
                d_ctrl.alu_from_funct = 1'b1;
            end
            op_addi:
            begin
                d_ctrl.reg_write   = 1'b1;
                d_ctrl.alu_src_imm = 1'b1;
            end
            op_lw:
            begin
                d_ctrl.reg_write   = 1'b1;
                d_ctrl.mem_read    = 1'b1;
                d_ctrl.mem_to_reg  = 1'b1;
                d_ctrl.alu_src_imm = 1'b1;
            end
            op_sw:
            begin
                d_ctrl.mem_write   = 1'b1;
                d_ctrl.alu_src_imm = 1'b1;
            end
            default: d_ctrl = '0;    // unknown opcode runs as nop
        endcase
    end

    assign d_dest = d_ctrl.reg_dst_rd ? d_instr.r.rd : d_instr.i.rt;
    assign d_imm  = {{(xlen-16){d_instr.i.imm[15]}}, d_instr.i.imm};

    reg_file i_reg_file (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .rs_addr    (d_instr.r.rs),
        .rt_addr    (d_instr.r.rt),
        .dbg_addr   (dbg_addr),
        .write      (wb_write),
        .write_addr (wb_dest),
        .write_data (wb_data),
        .rs_data    (rf_rs),
        .rt_data    (rf_rt),
        .dbg_data   (dbg_data)
    );

    always_comb
    begin
        case (fwd_a)
            fwd_mem: d_op_a = mem_result;
            fwd_wb:  d_op_a = wb_data;    // not yet in the file this cycle
            default: d_op_a = rf_rs;
        endcase
        case (fwd_b)
            fwd_mem: d_op_b = mem_result;
            fwd_wb:  d_op_b = wb_data;
            default: d_op_b = rf_rt;
        endcase
    end

endmodule

/* src/execute_stage.sv */
/*
  Execute stage: pipeline register with bubble insertion on stall, ALU control
  from the control bits and funct, and the ALU itself.
*/
`timescale 1ns/100ps

module execute_stage (
    input  logic                            SYS_clk,
    input  logic                            SYS_reset,
    input  logic                            stall,
    input  mips_pkg::instr_t                d_instr,
    input  mips_pkg::ctrl_t                 d_ctrl,
    input  logic [mips_pkg::xlen-1:0]       d_op_a,
    input  logic [mips_pkg::xlen-1:0]       d_op_b,
    input  logic [mips_pkg::xlen-1:0]       d_imm,
    input  logic [mips_pkg::reg_addr_w-1:0] d_dest,
    output mips_pkg::ctrl_t                 ex_ctrl,
    output logic [mips_pkg::reg_addr_w-1:0] ex_dest,
    output logic [mips_pkg::xlen-1:0]       ex_result,
    output logic [mips_pkg::xlen-1:0]       ex_store_data
);
    import mips_pkg::*;

    instr_t          ex_instr;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] alu_b;
    alu_op_t         alu_op;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
        begin
            ex_instr <= '0;          // bubble
            ex_ctrl  <= '0;
            ex_dest  <= '0;
        end
        else
        begin
            ex_instr <= d_instr;
            ex_ctrl  <= d_ctrl;
            ex_dest  <= d_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        op_a <= d_op_a;
        op_b <= d_op_b;
        imm  <= d_imm;
    end

    always_comb
    begin
        alu_op = alu_add;            // addi, lw, sw address
        if (ex_ctrl.alu_from_funct)
        begin
            case (ex_instr.r.funct)
                fn_sub:  alu_op = alu_sub;
                fn_and:  alu_op = alu_and;
                fn_or:   alu_op = alu_or;
                fn_slt:  alu_op = alu_slt;
                default: alu_op = alu_add;
            endcase
        end
    end

    assign alu_b = ex_ctrl.alu_src_imm ? imm : op_b;

    always_comb
    begin
        case (alu_op)
            alu_sub: ex_result = op_a - alu_b;
            alu_and: ex_result = op_a & alu_b;
            alu_or:  ex_result = op_a | alu_b;
            alu_slt: ex_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: ex_result = op_a + alu_b;
        endcase
    end

    assign ex_store_data = op_b;

endmodule

/* src/mem_wb_stage.sv */
/*
  Memory and writeback stages. Holds the data memory, produces the memory-stage
  result for forwarding and the registered writeback bundle for the register file.
*/
`timescale 1ns/100ps

module mem_wb_stage (
    input  logic                            SYS_clk,
    input  logic                            SYS_reset,
    input  mips_pkg::ctrl_t                 ex_ctrl,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_dest,
    input  logic [mips_pkg::xlen-1:0]       ex_result,
    input  logic [mips_pkg::xlen-1:0]       ex_store_data,
    output logic [mips_pkg::reg_addr_w-1:0] mem_dest,
    output logic                            mem_reg_write,
    output logic [mips_pkg::xlen-1:0]       mem_result,
    output logic                            wb_write,
    output logic [mips_pkg::reg_addr_w-1:0] wb_dest,
    output logic [mips_pkg::xlen-1:0]       wb_data
);
    import mips_pkg::*;

    localparam int dmem_aw = $clog2(dmem_words);

    ctrl_t              mem_ctrl;
    logic [xlen-1:0]    mem_alu;
    logic [xlen-1:0]    mem_wdata;
    logic [dmem_aw-1:0] dmem_addr;
    logic [xlen-1:0]    load_data;
    logic [xlen-1:0]    dmem [dmem_words];

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_ctrl <= '0;
            mem_dest <= '0;
        end
        else
        begin
            mem_ctrl <= ex_ctrl;
            mem_dest <= ex_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_alu   <= ex_result;
        mem_wdata <= ex_store_data;
    end

    assign dmem_addr = mem_alu[dmem_aw+1:2];    // word address

    always_ff @(posedge SYS_clk)
    begin
        if (mem_ctrl.mem_write)
            dmem[dmem_addr] <= mem_wdata;
    end

    assign load_data     = mem_ctrl.mem_read ? dmem[dmem_addr] : '0;
    assign mem_result    = mem_ctrl.mem_to_reg ? load_data : mem_alu;
    assign mem_reg_write = mem_ctrl.reg_write;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_write <= 1'b0;
            wb_dest  <= '0;
        end
        else
        begin
            wb_write <= mem_ctrl.reg_write;
            wb_dest  <= mem_dest;
        end
    end

    always_ff @(posedge SYS_clk)
        wb_data <= mem_result;

    a_no_rd_wr: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(mem_ctrl.mem_read && mem_ctrl.mem_write))
        else $error("load and store active together in memory stage");

endmodule

/* src/mips_core.sv */
/*
  Top of the five-stage core. Owns the PC and connects the stages and the hazard
  unit; instruction memory sits outside and answers combinationally to pc.
*/
`timescale 1ns/100ps

module mips_core (
    input  logic                            SYS_clk,
    input  logic                            SYS_reset,
    input  mips_pkg::instr_t                instr,
    input  logic [mips_pkg::reg_addr_w-1:0] dbg_addr,
    output logic [mips_pkg::xlen-1:0]       pc,
    output logic [mips_pkg::xlen-1:0]       dbg_data
);
    import mips_pkg::*;

    logic                  stall;
    fwd_sel_t              fwd_a;
    fwd_sel_t              fwd_b;
    instr_t                d_instr;
    ctrl_t                 d_ctrl;
    logic [xlen-1:0]       d_op_a;
    logic [xlen-1:0]       d_op_b;
    logic [xlen-1:0]       d_imm;
    logic [reg_addr_w-1:0] d_dest;
    ctrl_t                 ex_ctrl;
    logic [reg_addr_w-1:0] ex_dest;
    logic [xlen-1:0]       ex_result;
    logic [xlen-1:0]       ex_store_data;
    logic [reg_addr_w-1:0] mem_dest;
    logic                  mem_reg_write;
    logic [xlen-1:0]       mem_result;
    logic                  wb_write;
    logic [reg_addr_w-1:0] wb_dest;
    logic [xlen-1:0]       wb_data;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= '0;
        else if (!stall)
            pc <= pc + xlen'(4);     // no branches, straight line fetch
    end

    hazard_unit i_hazard_unit (
        .d_instr       (d_instr),
        .ex_dest       (ex_dest),
        .ex_reg_write  (ex_ctrl.reg_write),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .wb_dest       (wb_dest),
        .wb_reg_write  (wb_write),
        .stall         (stall),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    decode_stage i_decode_stage (
        .SYS_clk (SYS_clk), .SYS_reset (SYS_reset),
        .fetch_instr (instr), .stall (stall), .fwd_a (fwd_a), .fwd_b (fwd_b),
        .mem_result (mem_result), .wb_write (wb_write), .wb_dest (wb_dest),
        .wb_data (wb_data), .dbg_addr (dbg_addr),
        .d_instr (d_instr), .d_ctrl (d_ctrl), .d_op_a (d_op_a), .d_op_b (d_op_b),
        .d_imm (d_imm), .d_dest (d_dest), .dbg_data (dbg_data)
    );

    execute_stage i_execute_stage (
        .SYS_clk (SYS_clk), .SYS_reset (SYS_reset), .stall (stall),
        .d_instr (d_instr), .d_ctrl (d_ctrl), .d_op_a (d_op_a), .d_op_b (d_op_b),
        .d_imm (d_imm), .d_dest (d_dest),
        .ex_ctrl (ex_ctrl), .ex_dest (ex_dest), .ex_result (ex_result),
        .ex_store_data (ex_store_data)
    );

    mem_wb_stage i_mem_wb_stage (
        .SYS_clk (SYS_clk), .SYS_reset (SYS_reset),
        .ex_ctrl (ex_ctrl), .ex_dest (ex_dest), .ex_result (ex_result),
        .ex_store_data (ex_store_data),
        .mem_dest (mem_dest), .mem_reg_write (mem_reg_write), .mem_result (mem_result),
        .wb_write (wb_write), .wb_dest (wb_dest), .wb_data (wb_data)
    );

    a_pc_aligned: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    a_pc_held: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        stall |=> $stable(pc))
        else $error("pc moved during stall");

endmodule

/* tests/mips_core_tb.sv */
/*
  Testbench for the five-stage core. Models the instruction memory, runs a short
  program full of hazards and checks every register through the debug port.
*/
`timescale 1ns/100ps

module mips_core_tb;
    import mips_pkg::*;

    localparam int prog_len     = 18;
    localparam int n_checks     = 16;
    localparam int drain_cycles = 5;
    localparam int cycle_limit  = prog_len + prog_len + drain_cycles + 20;  // one stall each

    logic        SYS_clk;
    logic        SYS_reset;
    instr_t      instr;
    logic [4:0]  dbg_addr;
    logic [31:0] pc;
    logic [31:0] dbg_data;

    logic [31:0] imem [0:prog_len-1];
    logic [31:0] model_regs [0:31];
    logic [31:0] model_mem [0:dmem_words-1];
    string       exp_name [0:n_checks-1];
    logic [4:0]  exp_reg [0:n_checks-1];
    logic [31:0] exp_val [0:n_checks-1];

    int   seed;
    int   pass_count;
    int   fail_count;
    int   cycles;
    logic prog_done;

    mips_core i_mips_core (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .instr     (instr),
        .dbg_addr  (dbg_addr),
        .pc        (pc),
        .dbg_data  (dbg_data)
    );

    always #4 SYS_clk = ~SYS_clk;

    function automatic logic [31:0] enc_r(input logic [5:0] funct,
                                          input logic [4:0] rd, input logic [4:0] rs,
                                          input logic [4:0] rt);
        return {op_rtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] word;
        word = '0;                               // nop past the end and before reset
        if (!$isunknown(addr) && addr[31:2] < prog_len)
            word = imem[addr[31:2]];
        return word;
    endfunction

    assign instr = fetch_word(pc);

    task automatic build_program();
        logic [31:0] rnd;
        logic [15:0] imm_pos;
        logic [15:0] imm_neg;
        logic [15:0] imm_c;
        logic [15:0] imm_d;
        logic [15:0] imm_e;
        rnd     = $random(seed);
        imm_pos = {1'b0, rnd[14:0]};
        rnd     = $random(seed);
        imm_neg = {1'b1, rnd[14:0]};
        rnd     = $random(seed);
        imm_c   = rnd[15:0];
        rnd     = $random(seed);
        imm_d   = rnd[15:0];
        rnd     = $random(seed);
        imm_e   = rnd[15:0];
        imem[0]  = enc_i(op_addi, 5'd1, 5'd0, imm_pos);
        imem[1]  = enc_i(op_addi, 5'd2, 5'd0, imm_neg);
        imem[2]  = enc_r(fn_add, 5'd3, 5'd1, 5'd2);      // r2 at distance one
        imem[3]  = enc_r(fn_sub, 5'd4, 5'd1, 5'd2);
        imem[4]  = enc_r(fn_and, 5'd5, 5'd3, 5'd4);      // stall, then mem and wb forward
        imem[5]  = enc_r(fn_or, 5'd6, 5'd5, 5'd1);
        imem[6]  = enc_r(fn_slt, 5'd7, 5'd2, 5'd1);      // negative below positive
        imem[7]  = enc_r(fn_slt, 5'd8, 5'd1, 5'd2);
        imem[8]  = enc_i(op_addi, 5'd9, 5'd6, imm_c);    // r6 at distance three
        imem[9]  = enc_i(op_sw, 5'd4, 5'd0, 16'd12);
        imem[10] = enc_i(op_lw, 5'd10, 5'd0, 16'd12);
        imem[11] = enc_r(fn_add, 5'd11, 5'd10, 5'd1);    // load result used at once
        imem[12] = enc_i(op_addi, 5'd0, 5'd0, imm_d);    // write to r0
        imem[13] = enc_r(fn_add, 5'd12, 5'd0, 5'd9);
        imem[14] = enc_i(op_sw, 5'd11, 5'd0, 16'd20);
        imem[15] = enc_i(op_lw, 5'd13, 5'd0, 16'd20);
        imem[16] = enc_r(fn_sub, 5'd14, 5'd13, 5'd7);
        imem[17] = enc_i(op_addi, 5'd15, 5'd14, imm_e);
    endtask

    task automatic write_model(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0)
            model_regs[rd] = value;
    endtask

    // executes the program one instruction at a time, no pipeline
    task automatic run_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] res;
        for (int k = 0; k < 32; k++)
            model_regs[k] = '0;
        for (int k = 0; k < dmem_words; k++)
            model_mem[k] = '0;
        for (int p = 0; p < prog_len; p++)
        begin
            w    = imem[p];
            a    = model_regs[w[25:21]];
            b    = model_regs[w[20:16]];
            imm  = {{16{w[15]}}, w[15:0]};
            addr = a + imm;
            res  = '0;
            case (w[31:26])
                op_rtype:
                begin
                    case (w[5:0])
                        fn_add:  res = a + b;
                        fn_sub:  res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = 'x;
                    endcase
                    write_model(w[15:11], res);
                end
                op_addi: write_model(w[20:16], addr);
                op_lw:   write_model(w[20:16], model_mem[addr[7:2]]);
                op_sw:   model_mem[addr[7:2]] = b;
                default: ;
            endcase
        end
    endtask

    task automatic fill_expectations();
        exp_name = '{"r0_write_ignored", "addi_positive", "addi_negative", "add_stall_fwd",
                     "sub", "and_mem_wb_fwd", "or_after_stall", "slt_signed_true",
                     "slt_signed_false", "addi_wb_fwd", "lw_after_sw", "add_load_use",
                     "add_reads_r0", "lw_fwd_store", "sub_load_use", "addi_random"};
        for (int k = 0; k < n_checks; k++)
        begin
            exp_reg[k] = k[4:0];
            exp_val[k] = model_regs[k];
        end
    endtask

    task automatic check_reset();
        int bad;
        bad = 0;
        for (int k = 0; k < 4; k++)
        begin
            @(negedge SYS_clk);
            if (k == 3)
                SYS_reset = 1'b0;                // released after the fourth edge
            assert (pc === 32'h0)
            else
            begin
                $display("Error: reset_pc expected %h actual %h", 32'h0, pc);
                bad++;
            end
        end
        // sweep the debug port inside the low phase
        for (int r = 0; r < 32; r++)
        begin
            dbg_addr = r[4:0];
            #0.1;
            assert (dbg_data === 32'h0)
            else
            begin
                $display("Error: reset_r%0d expected %h actual %h", r, 32'h0, dbg_data);
                bad++;
            end
        end
        dbg_addr = '0;
        if (bad == 0)
        begin
            pass_count++;
            $display("ok    reset_state");
        end
        else
            fail_count++;
    endtask

    task automatic check_reg(input string name, input logic [4:0] r,
                             input logic [31:0] expected);
        logic [31:0] actual;
        dbg_addr = r;
        #2;
        actual = dbg_data;
        assert (actual === expected)
        begin
            pass_count++;
            $display("ok    %s r%0d = %h", name, r, actual);
        end
        else
        begin
            fail_count++;
            $display("Error: %s r%0d expected %h actual %h", name, r, expected, actual);
        end
    endtask

    always @(posedge SYS_clk)
    begin
        if (!SYS_reset && !prog_done)
        begin
            cycles++;
            if (cycles > cycle_limit)
            begin
                $display("Timeout: the program did not finish within %0d cycles", cycle_limit);
                $display("*** TEST FAILED ***");
                $finish;
            end
        end
    end

    initial
    begin
        SYS_clk    = 1'b0;
        SYS_reset  = 1'b1;
        dbg_addr   = '0;
        seed       = 61;
        pass_count = 0;
        fail_count = 0;
        cycles     = 0;
        prog_done  = 1'b0;
        build_program();
        run_model();
        fill_expectations();
        check_reset();
        while (pc !== 32'(4 * prog_len))
            @(negedge SYS_clk);
        repeat (drain_cycles) @(negedge SYS_clk);    // last write plus one stall
        prog_done = 1'b1;
        for (int t = 0; t < n_checks; t++)
        begin
            @(negedge SYS_clk);
            check_reg(exp_name[t], exp_reg[t], exp_val[t]);
        end
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* all.f */
src/mips_pkg.sv
src/hazard_unit.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/mips_core.sv
tests/mips_core_tb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - src/mips_pkg.sv
  - src/hazard_unit.sv
  - src/reg_file.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/mem_wb_stage.sv
  - src/mips_core.sv
  - target: test
    files:
      - tests/mips_core_tb.sv
